//--- bench/rv_ref_model.svh
// architectural reference for the RV32I subset; no pipeline timing, include inside a module
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// architectural registers, x0 is never written
logic [31:0] arch_regs [0:31];

function automatic bit ref_legal(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
        op_lui, op_auipc, op_jal: return 1'b1;
        op_jalr:   return f3 == 3'b000;
        op_branch: return (f3 != 3'b010) && (f3 != 3'b011);
        op_imm: begin
            if (f3 == f3_sll) return f7 == f7_zero;
            if (f3 == f3_sr) return (f7 == f7_zero) || (f7 == f7_alt);
            return 1'b1;
        end
        op_reg:  return (f7 == f7_zero) || ((f7 == f7_alt) && (f3 == f3_add || f3 == f3_sr));
        default: return 1'b0;
    endcase
endfunction

function automatic logic [31:0] ref_alu(input logic [31:0] w, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (w[14:12])
        f3_add:  return (w[6:0] == op_reg && w[30]) ? a - b : a + b;
        f3_sll:  return a << sh;
        f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        f3_sltu: return (a < b) ? 32'd1 : 32'd0;
        f3_xor:  return a ^ b;
        f3_sr:   return w[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
        f3_or:   return a | b;
        default: return a & b;
    endcase
endfunction

function automatic bit ref_taken(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
    case (f3)
        f3_beq:  return a == b;
        f3_bne:  return a != b;
        f3_blt:  return $signed(a) < $signed(b);
        f3_bge:  return $signed(a) >= $signed(b);
        f3_bltu: return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic logic [31:0] ref_target(input logic [31:0] w, input logic [31:0] wpc,
                                           input logic [31:0] a);
    case (w[6:0])
        op_jal:  return wpc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        op_jalr: return (a + {{20{w[31]}}, w[31:20]}) & 32'hffff_fffe;
        default: return wpc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endcase
endfunction

function automatic logic [31:0] ref_result(input logic [31:0] w, input logic [31:0] wpc,
                                           input logic [31:0] a, input logic [31:0] b);
    case (w[6:0])
        op_lui:          return {w[31:12], 12'h000};
        op_auipc:        return wpc + {w[31:12], 12'h000};
        op_jal, op_jalr: return wpc + 32'd4;
        op_imm:          return ref_alu(w, a, {{20{w[31]}}, w[31:20]});
        default:         return ref_alu(w, a, b);
    endcase
endfunction

`endif

//--- bench/rv_core_tb.sv
// bench acts as fetch unit; programs hold only forward transfers inside 256 words
`timescale 1ns/100ps

module rv_core_tb;

    import rv_isa_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        hold;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wbk_valid;
    logic [4:0]  wbk_adr;
    logic [31:0] wbk_data;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        illegal;
    logic [31:0] illegal_pc;

    logic [31:0] prog [0:255];
    logic [36:0] wbk_q [$];
    logic [31:0] redir_q [$];
    logic [31:0] illeg_q [$];
    int          errors;
    int          checks;
    string       cur_test;

    `include "rv_ref_model.svh"

    rv_core_top i_rv_core_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .wbk_valid   (wbk_valid),
        .wbk_adr     (wbk_adr),
        .wbk_data    (wbk_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .illegal     (illegal),
        .illegal_pc  (illegal_pc)
    );

    always #5 clk = ~clk;

    task automatic check_wbk(input logic [4:0] exp_adr, input logic [xlen-1:0] exp_data,
                             input logic [4:0] act_adr, input logic [xlen-1:0] act_data);
        checks++;
        if (exp_adr !== act_adr || exp_data !== act_data) begin
            $display("error %s: writeback expected x%0d=%h, got x%0d=%h",
                     cur_test, exp_adr, exp_data, act_adr, act_data);
            errors++;
        end
    endtask

    task automatic check_redirect(input logic [xlen-1:0] exp_pc, input logic [xlen-1:0] act_pc);
        checks++;
        if (exp_pc !== act_pc) begin
            $display("error %s: redirect expected %h, got %h", cur_test, exp_pc, act_pc);
            errors++;
        end
    endtask

    task automatic check_illegal(input logic [xlen-1:0] exp_pc, input logic [xlen-1:0] act_pc);
        checks++;
        if (exp_pc !== act_pc) begin
            $display("error %s: illegal pc expected %h, got %h", cur_test, exp_pc, act_pc);
            errors++;
        end
    endtask

    // scoreboard, a redirect counts only at the edge that consumes it
    always @(negedge clk) begin
        logic [36:0] exp_w;
        if (rst_n && cur_test != "reset_idle") begin
            if (wbk_valid) begin
                if (wbk_q.size() == 0) begin
                    $display("%s: unexpected writeback to x%0d", cur_test, wbk_adr);
                    errors++;
                end else begin
                    exp_w = wbk_q.pop_front();
                    check_wbk(exp_w[36:32], exp_w[31:0], wbk_adr, wbk_data);
                end
            end
            if (redirect && !hold) begin
                if (redir_q.size() == 0) begin
                    $display("%s: unexpected redirect to %h", cur_test, redirect_pc);
                    errors++;
                end else begin
                    check_redirect(redir_q.pop_front(), redirect_pc);
                end
            end
            if (illegal) begin
                if (illeg_q.size() == 0) begin
                    $display("%s: unexpected illegal strobe at %h", cur_test, illegal_pc);
                    errors++;
                end else begin
                    check_illegal(illeg_q.pop_front(), illegal_pc);
                end
            end
        end
    end

    task automatic stop_on_timeout(input string what);
        $display("%s: %s within 200 cycles", cur_test, what);
        $display("Test FAILED");
        $finish;
    endtask

    function automatic logic [31:0] gen_alu(input int k);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        rd  = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        imm = 12'($urandom);
        if (k < 10) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? f3_add : f3_sr);
            return {(k >= 8) ? f7_alt : f7_zero, rs2, rs1, f3, rd, op_reg};
        end
        f3 = (k < 18) ? 3'(k - 10) : f3_sr;
        if (f3 == f3_sll || f3 == f3_sr) begin
            imm = {(k == 18) ? f7_alt : f7_zero, imm[4:0]};
        end
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic logic [31:0] gen_illegal();
        logic [31:0] r;
        r = $urandom;
        case ($urandom % 4)
            0:       return {r[31:7], 7'b0000011};
            1:       return {7'b0000001, r[24:7], op_reg};
            2:       return {r[31:15], 3'($urandom % 7 + 1), r[11:7], op_jalr};
            default: return {r[31:15], 3'b010, r[11:7], op_branch};
        endcase
    endfunction

    function automatic logic [31:0] gen_word(input int i, input bit ctl, input bit ill);
        int          sel;
        int          tgt;
        logic [20:0] off;
        logic [11:0] jimm;
        logic [2:0]  bf3;
        logic [4:0]  rd;
        sel = $urandom % 16;
        tgt = i + 1 + $urandom % 8;
        if (tgt > 255) tgt = 255;
        off  = 21'((tgt - i) * 4);
        // odd jalr offsets exercise the cleared target bit
        jimm = 12'(tgt * 4 + $urandom % 2);
        bf3  = 3'($urandom % 6);
        if (bf3 >= 3'd2) bf3 = bf3 + 3'd2;
        rd = 5'($urandom % 8);
        if (ill && sel == 0) return gen_illegal();
        if (sel == 1) return {20'($urandom), rd, op_lui};
        if (!ctl || i >= 255 || sel > 6) return gen_alu($urandom % 19);
        case (sel)
            2:       return {20'($urandom), rd, op_auipc};
            3:       return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
            4:       return {jimm, 5'd0, 3'b000, rd, op_jalr};
            default: return {off[12], off[10:5], 5'($urandom % 8), 5'($urandom % 8), bf3,
                             off[4:1], off[11], op_branch};
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] wpc);
        return (wpc < 32'd1024) ? prog[wpc[9:2]] : 32'h0000_0013;
    endfunction

    // runs one word in program order and queues what the DUT must show
    task automatic ref_step(input logic [31:0] w, input logic [31:0] wpc,
                            output logic [31:0] nxt, output bit taken);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [4:0]  rd;
        a     = arch_regs[w[19:15]];
        b     = arch_regs[w[24:20]];
        rd    = w[11:7];
        taken = 1'b0;
        nxt   = wpc + 32'd4;
        if (!ref_legal(w)) begin
            illeg_q.push_back(wpc);
            return;
        end
        res = ref_result(w, wpc, a, b);
        if (w[6:0] == op_jal || w[6:0] == op_jalr) begin
            taken = 1'b1;
        end else if (w[6:0] == op_branch) begin
            taken = ref_taken(w[14:12], a, b);
        end
        if (taken) begin
            nxt = ref_target(w, wpc, a);
            redir_q.push_back(nxt);
        end
        if (w[6:0] != op_branch && rd != 5'd0) begin
            arch_regs[rd] = res;
            wbk_q.push_back({rd, res});
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n      = 1'b0;
        hold       = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < 32; r++) begin
            arch_regs[r] = '0;
        end
        wbk_q.delete();
        redir_q.delete();
        illeg_q.delete();
    endtask

    task automatic run_program(input bit use_hold);
        logic [31:0] cur_pc;
        logic [31:0] nxt_pc;
        logic [31:0] tgt_pc;
        bit          taken;
        bit          skip;
        bit          accepted;
        int          waited;
        cur_pc = '0;
        tgt_pc = '0;
        skip   = 1'b0;
        while (cur_pc < 32'd1024 || skip) begin
            taken  = 1'b0;
            nxt_pc = cur_pc + 32'd4;
            if (!skip) ref_step(fetch_word(cur_pc), cur_pc, nxt_pc, taken);
            inst       = fetch_word(cur_pc);
            pc         = cur_pc;
            inst_valid = 1'b1;
            accepted   = 1'b0;
            waited     = 0;
            while (!accepted) begin
                hold = use_hold && (waited < 8) && ($urandom % 3 == 0);
                @(posedge clk);
                accepted = !hold;
                #1;
                waited++;
                if (waited > 200) stop_on_timeout("instruction was never accepted");
            end
            // the word after a taken transfer is purged by the core
            if (skip) begin
                skip   = 1'b0;
                cur_pc = tgt_pc;
            end else if (taken) begin
                skip   = 1'b1;
                tgt_pc = nxt_pc;
                cur_pc = cur_pc + 32'd4;
            end else begin
                cur_pc = nxt_pc;
            end
        end
        inst_valid = 1'b0;
        hold       = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (wbk_q.size() + redir_q.size() + illeg_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 200) stop_on_timeout("expected events still pending");
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic run_test(input string name, input bit ctl, input bit ill, input bit use_hold);
        int err0;
        int chk0;
        cur_test = name;
        err0     = errors;
        chk0     = checks;
        apply_reset();
        for (int i = 0; i < 256; i++) begin
            prog[i] = gen_word(i, ctl, ill);
        end
        // every OP and OP-IMM form once at the start
        if (!ctl) begin
            for (int k = 0; k < 19; k++) begin
                prog[k] = gen_alu(k);
            end
        end
        run_program(use_hold);
        drain();
        $display("test %-14s checks %0d errors %0d", name, checks - chk0, errors - err0);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        hold       = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        errors     = 0;
        checks     = 0;
        cur_test   = "reset_idle";
        void'($urandom(32'h555e_3a41));
        apply_reset();
        for (int c = 0; c < 10; c++) begin
            @(negedge clk);
            checks++;
            if (wbk_valid || redirect) begin
                $display("%s: output active before any instruction", cur_test);
                errors++;
            end
        end
        $display("test %-14s checks %0d errors %0d", cur_test, checks, errors);
        run_test("alu_stream", 1'b0, 1'b0, 1'b0);
        run_test("control_flow", 1'b1, 1'b0, 1'b0);
        run_test("illegal_words", 1'b1, 1'b1, 1'b0);
        run_test("random_hold", 1'b1, 1'b1, 1'b1);
        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+bench
source/rv_isa_pkg.sv
source/pipe_pkg.sv
source/stage_reg.sv
source/inst_decode.sv
source/int_execute.sv
source/result_write.sv
source/rv_core_top.sv
bench/rv_core_tb.sv

//--- source/inst_decode.sv
// combinational decode of the RV32I subset; only 32-bit encodings, every other word is illegal
`timescale 1ns/100ps

module inst_decode (
    input  logic [31:0]                  inst,
    input  logic [rv_isa_pkg::xlen-1:0]  pc,
    input  logic [rv_isa_pkg::xlen-1:0]  rs1_data,
    input  logic [rv_isa_pkg::xlen-1:0]  rs2_data,
    output logic [4:0]                   rs1_adr,
    output logic [4:0]                   rs2_adr,
    output pipe_pkg::ex_cmd_t            cmd,
    output logic                         illegal
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    function automatic logic [6:0] op_onehot(input logic [6:0] opc);
        case (opc)
            op_lui:    op_onehot = 7'b000_0001;
            op_auipc:  op_onehot = 7'b000_0010;
            op_jal:    op_onehot = 7'b000_0100;
            op_jalr:   op_onehot = 7'b000_1000;
            op_branch: op_onehot = 7'b001_0000;
            op_imm:    op_onehot = 7'b010_0000;
            op_reg:    op_onehot = 7'b100_0000;
            default:   op_onehot = 7'b000_0000;
        endcase
    endfunction

    function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt);
        case (f3)
            f3_add:  alu_map = alt ? alu_sub : alu_add;
            f3_sll:  alu_map = alu_sll;
            f3_slt:  alu_map = alu_slt;
            f3_sltu: alu_map = alu_sltu;
            f3_xor:  alu_map = alu_xor;
            f3_sr:   alu_map = alt ? alu_sra : alu_srl;
            f3_or:   alu_map = alu_or;
            default: alu_map = alu_and;
        endcase
    endfunction

    // field slices
    logic [6:0] opcode;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [6:0] f7;
    assign opcode  = inst[6:0];
    assign rd      = inst[11:7];
    assign f3      = inst[14:12];
    assign rs1_adr = inst[19:15];
    assign rs2_adr = inst[24:20];
    assign f7      = inst[31:25];

    logic [xlen-1:0] imm_i, imm_u, imm_j, imm_b;
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    logic [6:0] dc_op;
    logic dc_lui, dc_auipc, dc_jal, dc_jalr, dc_br, dc_imm, dc_reg;
    assign dc_op = op_onehot(opcode);
    assign {dc_reg, dc_imm, dc_br, dc_jalr, dc_jal, dc_auipc, dc_lui} = dc_op;

    // reserved bit checks
    logic f7_zero_ok, f7_alt_ok, is_sll, is_sr, imm_ok, reg_ok, br_ok, legal, alt_sel;
    assign f7_zero_ok = (f7 == f7_zero);
    assign f7_alt_ok  = (f7 == f7_alt);
    assign is_sll     = (f3 == f3_sll);
    assign is_sr      = (f3 == f3_sr);
    assign imm_ok     = (~is_sll & ~is_sr) | (is_sll & f7_zero_ok) |
                        (is_sr & (f7_zero_ok | f7_alt_ok));
    assign reg_ok     = f7_zero_ok | (f7_alt_ok & ((f3 == f3_add) | is_sr));
    assign br_ok      = (f3 != 3'b010) & (f3 != 3'b011);
    assign legal      = dc_lui | dc_auipc | dc_jal | (dc_jalr & (f3 == 3'd0)) |
                        (dc_br & br_ok) | (dc_imm & imm_ok) | (dc_reg & reg_ok);
    assign illegal    = ~legal;

    // addi has no alternate form, bit 30 is immediate there
    assign alt_sel = dc_imm ? (is_sr & f7_alt_ok) : f7_alt_ok;

    always_comb begin
        cmd           = '0;
        cmd.valid     = legal;
        cmd.use_pc    = dc_auipc;
        cmd.use_imm   = dc_lui | dc_auipc | dc_imm;
        cmd.is_jal    = dc_jal;
        cmd.is_jalr   = dc_jalr;
        cmd.is_branch = dc_br;
        cmd.br_f3     = f3;
        cmd.rd        = rd;
        cmd.wbk_en    = legal & ~dc_br;
        cmd.rs1       = rs1_adr;
        cmd.rs2       = rs2_adr;
        cmd.rs1_data  = rs1_data;
        cmd.rs2_data  = rs2_data;
        cmd.pc        = pc;
        if (dc_lui | dc_auipc) begin
            cmd.imm = imm_u;
        end else if (dc_jal) begin
            cmd.imm = imm_j;
        end else if (dc_br) begin
            cmd.imm = imm_b;
        end else begin
            cmd.imm = imm_i;
        end
        if (dc_lui) begin
            cmd.alu_op = alu_pass_b;
        end else if (dc_imm | dc_reg) begin
            cmd.alu_op = alu_map(f3, alt_sel);
        end else begin
            cmd.alu_op = alu_add;
        end
    end

endmodule

//--- source/int_execute.sv
// combinational execute; forwards only from the result register, jalr target bit 0 is cleared
`timescale 1ns/100ps

module int_execute (
    input  pipe_pkg::ex_cmd_t cmd,
    input  logic              cmd_valid,
    input  logic              fwd_valid,
    input  logic [4:0]        fwd_rd,
    input  logic [31:0]       fwd_data,
    output pipe_pkg::wb_cmd_t result,
    output logic              result_valid,
    output logic              redirect,
    output logic [31:0]       redirect_pc
);

    import rv_isa_pkg::*;
    import pipe_pkg::*;

    // forwarding from wb_reg
    logic            fwd_rs1, fwd_rs2;
    logic [xlen-1:0] rs1_val, rs2_val;
    assign fwd_rs1 = fwd_valid && (fwd_rd != 5'd0) && (fwd_rd == cmd.rs1);
    assign fwd_rs2 = fwd_valid && (fwd_rd != 5'd0) && (fwd_rd == cmd.rs2);
    assign rs1_val = fwd_rs1 ? fwd_data : cmd.rs1_data;
    assign rs2_val = fwd_rs2 ? fwd_data : cmd.rs2_data;

    logic [xlen-1:0] op_a, op_b, alu_out;
    logic [4:0]      shamt;
    assign op_a  = cmd.use_pc ? cmd.pc : rs1_val;
    assign op_b  = cmd.use_imm ? cmd.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (cmd.alu_op)
            alu_add:    alu_out = op_a + op_b;
            alu_sub:    alu_out = op_a - op_b;
            alu_sll:    alu_out = op_a << shamt;
            alu_slt:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_out = {31'd0, op_a < op_b};
            alu_xor:    alu_out = op_a ^ op_b;
            alu_srl:    alu_out = op_a >> shamt;
            alu_sra:    alu_out = $unsigned($signed(op_a) >>> shamt);
            alu_or:     alu_out = op_a | op_b;
            alu_and:    alu_out = op_a & op_b;
            alu_pass_b: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // branch compare on register values
    logic br_eq, br_lt, br_ltu, br_taken;
    assign br_eq  = (rs1_val == rs2_val);
    assign br_lt  = $signed(rs1_val) < $signed(rs2_val);
    assign br_ltu = rs1_val < rs2_val;

    always_comb begin
        case (cmd.br_f3)
            f3_beq:  br_taken = br_eq;
            f3_bne:  br_taken = ~br_eq;
            f3_blt:  br_taken = br_lt;
            f3_bge:  br_taken = ~br_lt;
            f3_bltu: br_taken = br_ltu;
            f3_bgeu: br_taken = ~br_ltu;
            default: br_taken = 1'b0;
        endcase
    end

    // link value and transfer target
    logic            is_jump;
    logic [xlen-1:0] link, tgt_base, tgt_sum;
    assign is_jump  = cmd.is_jal | cmd.is_jalr;
    assign link     = cmd.pc + 32'd4;
    assign tgt_base = cmd.is_jalr ? rs1_val : cmd.pc;
    assign tgt_sum  = tgt_base + cmd.imm;

    assign redirect    = cmd_valid & (is_jump | (cmd.is_branch & br_taken));
    assign redirect_pc = cmd.is_jalr ? {tgt_sum[xlen-1:1], 1'b0} : tgt_sum;

    assign result_valid = cmd_valid & cmd.wbk_en;
    assign result.valid = result_valid;
    assign result.rd    = cmd.rd;
    assign result.data  = is_jump ? link : alu_out;

endmodule

//--- source/pipe_pkg.sv
// pipeline payloads for the three-stage core; widths follow rv_isa_pkg::xlen
package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // decode to execute
    typedef struct packed {
        logic                        valid;
        alu_op_e                     alu_op;
        logic                        use_pc;
        logic                        use_imm;
        logic                        is_jal;
        logic                        is_jalr;
        logic                        is_branch;
        logic [2:0]                  br_f3;
        logic [4:0]                  rd;
        logic                        wbk_en;
        logic [4:0]                  rs1;
        logic [4:0]                  rs2;
        logic [rv_isa_pkg::xlen-1:0] rs1_data;
        logic [rv_isa_pkg::xlen-1:0] rs2_data;
        logic [rv_isa_pkg::xlen-1:0] imm;
        logic [rv_isa_pkg::xlen-1:0] pc;
    } ex_cmd_t;

    // execute to result
    typedef struct packed {
        logic                        valid;
        logic [4:0]                  rd;
        logic [rv_isa_pkg::xlen-1:0] data;
    } wb_cmd_t;

endpackage

//--- source/result_write.sv
// x1 to x31 in flops with async clear; x0 reads zero and is never written
`timescale 1ns/100ps

module result_write (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::wb_cmd_t wb,
    input  logic              wb_valid,
    input  logic [4:0]        rs1_adr,
    input  logic [4:0]        rs2_adr,
    output logic [31:0]       rs1_data,
    output logic [31:0]       rs2_data,
    output logic              wbk_valid,
    output logic [4:0]        wbk_adr,
    output logic [31:0]       wbk_data
);

    logic [31:0] regs [1:31];
    logic        wr_en;

    assign wr_en = wb_valid & wb.valid & (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is visible to the reader
    assign rs1_data = (rs1_adr == 5'd0) ? '0 :
                      (wr_en && (wb.rd == rs1_adr)) ? wb.data : regs[rs1_adr];
    assign rs2_data = (rs2_adr == 5'd0) ? '0 :
                      (wr_en && (wb.rd == rs2_adr)) ? wb.data : regs[rs2_adr];

    assign wbk_valid = wr_en;
    assign wbk_adr   = wb.rd;
    assign wbk_data  = wb.data;

endmodule

//--- source/rv_core_top.sv
// three-stage RV32I subset core; hold freezes all stages, one fetch slot is lost per taken jump
`timescale 1ns/100ps

module rv_core_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hold,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        wbk_valid,
    output logic [4:0]  wbk_adr,
    output logic [31:0] wbk_data,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        illegal,
    output logic [31:0] illegal_pc
);

    import pipe_pkg::*;

    logic [4:0]  rs1_adr, rs2_adr;
    logic [31:0] rs1_data, rs2_data;
    ex_cmd_t     dec_cmd, ex_cmd;
    logic        dec_illegal, ex_valid;
    wb_cmd_t     ex_result, wb_cmd;
    logic        ex_result_valid, wb_valid;

    inst_decode i_inst_decode (
        .inst     (inst),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_adr  (rs1_adr),
        .rs2_adr  (rs2_adr),
        .cmd      (dec_cmd),
        .illegal  (dec_illegal)
    );

    // report only a word that is actually taken in and not squashed
    assign illegal    = dec_illegal & inst_valid & ~hold & ~redirect;
    assign illegal_pc = pc;

    stage_reg #(.payload_t(ex_cmd_t)) de_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (hold),
        .purge   (redirect),
        .d       (dec_cmd),
        .d_valid (inst_valid & dec_cmd.valid),
        .q       (ex_cmd),
        .q_valid (ex_valid)
    );

    int_execute i_int_execute (
        .cmd          (ex_cmd),
        .cmd_valid    (ex_valid),
        .fwd_valid    (wb_valid),
        .fwd_rd       (wb_cmd.rd),
        .fwd_data     (wb_cmd.data),
        .result       (ex_result),
        .result_valid (ex_result_valid),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    stage_reg #(.payload_t(wb_cmd_t)) wb_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (hold),
        .purge   (1'b0),
        .d       (ex_result),
        .d_valid (ex_result_valid),
        .q       (wb_cmd),
        .q_valid (wb_valid)
    );

    // commit once, at the edge wb_reg moves on
    result_write i_result_write (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb        (wb_cmd),
        .wb_valid  (wb_valid & ~hold),
        .rs1_adr   (rs1_adr),
        .rs2_adr   (rs2_adr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wbk_valid (wbk_valid),
        .wbk_adr   (wbk_adr),
        .wbk_data  (wbk_data)
    );

endmodule

//--- source/rv_isa_pkg.sv
// RV32I subset encodings only; loads, stores, fence, CSR and system opcodes are not listed
package rv_isa_pkg;

    // data width
    localparam int xlen = 32;

    // major opcodes, bits 6:0
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // funct3 for arithmetic and logic
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for conditional branches, 010 and 011 are reserved
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // funct7 values
    localparam logic [6:0] f7_zero = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

endpackage

//--- source/stage_reg.sv
// one-deep pipeline register; hold wins over purge, purge only clears the valid flag
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     purge,
    input  payload_t d,
    input  logic     d_valid,
    output payload_t q,
    output logic     q_valid
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q       <= '0;
            q_valid <= 1'b0;
        end else if (!hold) begin
            q       <= d;
            // squashed slot keeps its payload but is never acted on
            q_valid <= d_valid & ~purge;
        end
    end

endmodule
